// File: Makefile
# Verilator build for the system controller testbench

VERILATOR ?= verilator
TOP := sysctl_tb
FLIST := flist.f
BUILD_DIR := obj_dir
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS := --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS := +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# The simulator exits nonzero on $fatal, which fails this target
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: flist.f
hdl/soc_bus_pkg.sv
hdl/sysctl_pkg.sv
hdl/csr_bus_if.sv
hdl/reset_sequencer.sv
hdl/wb_csr_bridge.sv
hdl/sysctl_gpio.sv
hdl/sysctl_timer.sv
hdl/sysctl_top.sv
tests/sysctl_properties.sv
tests/sysctl_tb.sv

// File: hdl/csr_bus_if.sv
/* CSR slave link */

interface csr_bus_if import soc_bus_pkg::*; ();

	// Driven by the bridge
	csr_addr_t csr_a;
	logic csr_we;
	wb_data_t csr_dw;
	// Registered by the peripheral, zero when not addressed
	wb_data_t csr_dr;

	modport bridge (
		output csr_a,
		output csr_we,
		output csr_dw,
		input csr_dr
	);

	modport peripheral (
		input csr_a,
		input csr_we,
		input csr_dw,
		output csr_dr
	);

endinterface

// File: hdl/reset_sequencer.sv
/* Reset sequencer */

module reset_sequencer #(
	parameter int unsigned rst_hold_cycles = 1048575,
	parameter int unsigned flash_rst_cycles = 128
) (
	input logic sys_clk,
	input logic trigger_reset,
	input logic soft_reset_i,
	input logic [2:0] btn_i,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);

	localparam int unsigned hold_w = $clog2(rst_hold_cycles + 1);
	localparam int unsigned flash_w = $clog2(flash_rst_cycles + 1);

	logic rst_req;
	logic [hold_w-1:0] hold_cnt;
	logic [flash_w-1:0] flash_cnt;

	// All three buttons held together act as a reset
	always_ff @(posedge sys_clk) begin
		rst_req <= trigger_reset | soft_reset_i | (&btn_i);
	end

	//----------------------------------------
	// System reset hold
	//----------------------------------------
	// Reloads while the request is present, then runs down
	always_ff @(posedge sys_clk) begin
		if (rst_req) begin
			hold_cnt <= hold_w'(rst_hold_cycles);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
		sys_rst_o <= rst_req | (hold_cnt != '0);
	end

	//----------------------------------------
	// Flash reset release
	//----------------------------------------
	// Flash must leave reset well before the system does
	always_ff @(posedge sys_clk) begin
		if (rst_req) begin
			flash_cnt <= '0;
		end else if (flash_cnt != flash_w'(flash_rst_cycles)) begin
			flash_cnt <= flash_cnt + 1'b1;
		end
		flash_rst_n_o <= ~rst_req & (flash_cnt == flash_w'(flash_rst_cycles));
	end

endmodule

// File: hdl/soc_bus_pkg.sv
/* Wishbone and CSR bus definitions */

package soc_bus_pkg;

	//----------------------------------------
	// Bus widths
	//----------------------------------------
	localparam int unsigned WB_ADDR_W = 32;
	localparam int unsigned WB_DATA_W = 32;
	localparam int unsigned CSR_ADDR_W = 15;
	localparam int unsigned CSR_BANK_W = 5;
	localparam int unsigned CSR_REG_W = 10;
	// Word address starts at byte address bit 2
	localparam int unsigned CSR_ADDR_LSB = 2;

	typedef logic [WB_ADDR_W-1:0] wb_addr_t;
	typedef logic [WB_DATA_W-1:0] wb_data_t;
	typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
	typedef logic [CSR_BANK_W-1:0] csr_bank_t;
	typedef logic [CSR_REG_W-1:0] csr_reg_t;

	//----------------------------------------
	// CSR address fields
	//----------------------------------------
	function automatic csr_addr_t csr_addr_of(wb_addr_t adr);
		return adr[CSR_ADDR_LSB +: CSR_ADDR_W];
	endfunction

	// Bank sits in the upper field
	function automatic csr_bank_t csr_bank_of(csr_addr_t a);
		return a[CSR_REG_W +: CSR_BANK_W];
	endfunction

	function automatic csr_reg_t csr_reg_of(csr_addr_t a);
		return a[CSR_REG_W-1:0];
	endfunction

	// Bridge FSM
	typedef enum logic [1:0] {IDLE, ACCESS, READ_WAIT, ACK} bridge_state_t;

endpackage

// File: hdl/sysctl_gpio.sv
/* GPIO and system registers */

module sysctl_gpio import soc_bus_pkg::*; import sysctl_pkg::*; #(
	parameter csr_bank_t csr_bank = 5'd0,
	parameter wb_data_t system_id = DEFAULT_SYSTEM_ID
) (
	input logic sys_clk,
	input logic sys_rst,
	input gpio_in_t gpio_i,
	output gpio_out_t led_o,
	output logic irq_o,
	output logic soft_reset_o,
	csr_bus_if.peripheral csr
);

	gpio_in_t gpio_meta;
	gpio_in_t gpio_sync;
	gpio_in_t gpio_prev;
	gpio_in_t irq_en;
	logic selected;
	csr_reg_t reg_idx;

	assign selected = (csr_bank_of(csr.csr_a) == csr_bank);
	assign reg_idx = csr_reg_of(csr.csr_a);

	//----------------------------------------
	// Input synchronizer
	//----------------------------------------
	// Two stages, plus one more for edge detect
	always_ff @(posedge sys_clk) begin
		gpio_meta <= gpio_i;
		gpio_sync <= gpio_meta;
		gpio_prev <= gpio_sync;
	end

	//----------------------------------------
	// Control registers
	//----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			led_o <= '0;
			irq_en <= '0;
			irq_o <= 1'b0;
			soft_reset_o <= 1'b0;
		end else begin
			// Any enabled bit toggling
			irq_o <= |((gpio_sync ^ gpio_prev) & irq_en);
			soft_reset_o <= 1'b0;
			if (csr.csr_we && selected) begin
				case (reg_idx)
					csr_reg_t'(REG_GPIO_OUT): led_o <= gpio_out_t'(csr.csr_dw);
					csr_reg_t'(REG_GPIO_IRQ_EN): irq_en <= gpio_in_t'(csr.csr_dw);
					// Data value is ignored
					csr_reg_t'(REG_HARD_RESET): soft_reset_o <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	// Read back, zero unless this bank is addressed
	always_ff @(posedge sys_clk) begin
		csr.csr_dr <= '0;
		if (selected) begin
			case (reg_idx)
				csr_reg_t'(REG_GPIO_IN): csr.csr_dr <= wb_data_t'(gpio_sync);
				csr_reg_t'(REG_GPIO_OUT): csr.csr_dr <= wb_data_t'(led_o);
				csr_reg_t'(REG_GPIO_IRQ_EN): csr.csr_dr <= wb_data_t'(irq_en);
				csr_reg_t'(REG_SYSTEM_ID): csr.csr_dr <= system_id;
				default: csr.csr_dr <= '0;
			endcase
		end
	end

endmodule

// File: hdl/sysctl_pkg.sv
/* System controller definitions */

package sysctl_pkg;

	//----------------------------------------
	// GPIO widths
	//----------------------------------------
	// PCB revision in [6:3], buttons 3..1 in [2:0]
	localparam int unsigned GPIO_IN_W = 7;
	localparam int unsigned GPIO_OUT_W = 2;
	localparam int unsigned IRQ_W = 3;

	typedef logic [GPIO_IN_W-1:0] gpio_in_t;
	typedef logic [GPIO_OUT_W-1:0] gpio_out_t;
	typedef logic [IRQ_W-1:0] irq_vec_t;

	// Interrupt vector bit positions
	localparam int unsigned IRQ_GPIO = 0;
	localparam int unsigned IRQ_TIMER0 = 1;
	localparam int unsigned IRQ_TIMER1 = 2;

	//----------------------------------------
	// GPIO bank register offsets
	//----------------------------------------
	localparam int unsigned REG_GPIO_IN = 0;
	localparam int unsigned REG_GPIO_OUT = 1;
	localparam int unsigned REG_GPIO_IRQ_EN = 2;
	localparam int unsigned REG_SYSTEM_ID = 3;
	// Any write here requests a reset
	localparam int unsigned REG_HARD_RESET = 4;

	//----------------------------------------
	// Timer bank register offsets
	//----------------------------------------
	// Bit 0 enable, bit 1 autoreload
	localparam int unsigned REG_TIMER_CTRL = 0;
	localparam int unsigned REG_TIMER_COMPARE = 1;
	localparam int unsigned REG_TIMER_COUNTER = 2;

	// Identity word returned by REG_SYSTEM_ID
	localparam logic [31:0] DEFAULT_SYSTEM_ID = 32'h5C7C_0100;

endpackage

// File: hdl/sysctl_timer.sv
/* Compare timer */

module sysctl_timer import soc_bus_pkg::*; import sysctl_pkg::*; #(
	parameter csr_bank_t csr_bank = 5'd1
) (
	input logic sys_clk,
	input logic sys_rst,
	output logic irq_o,
	csr_bus_if.peripheral csr
);

	logic enable;
	logic autoreload;
	wb_data_t compare;
	wb_data_t counter;
	logic selected;
	logic match;
	csr_reg_t reg_idx;

	assign selected = (csr_bank_of(csr.csr_a) == csr_bank);
	assign reg_idx = csr_reg_of(csr.csr_a);
	assign match = (counter == compare);

	//----------------------------------------
	// Counter and registers
	//----------------------------------------
	// Period is compare + 1 cycles
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			enable <= 1'b0;
			autoreload <= 1'b0;
			compare <= '0;
			counter <= '0;
			irq_o <= 1'b0;
		end else begin
			irq_o <= 1'b0;
			if (enable) begin
				if (match) begin
					irq_o <= 1'b1;
					counter <= '0;
					// One-shot stops itself
					if (!autoreload) begin
						enable <= 1'b0;
					end
				end else begin
					counter <= counter + 1'b1;
				end
			end
			// Bus writes win over the count
			if (csr.csr_we && selected) begin
				case (reg_idx)
					csr_reg_t'(REG_TIMER_CTRL): begin
						enable <= csr.csr_dw[0];
						autoreload <= csr.csr_dw[1];
					end
					csr_reg_t'(REG_TIMER_COMPARE): compare <= csr.csr_dw;
					csr_reg_t'(REG_TIMER_COUNTER): counter <= csr.csr_dw;
					default: ;
				endcase
			end
		end
	end

	// Read back
	always_ff @(posedge sys_clk) begin
		csr.csr_dr <= '0;
		if (selected) begin
			case (reg_idx)
				csr_reg_t'(REG_TIMER_CTRL): csr.csr_dr <= {30'd0, autoreload, enable};
				csr_reg_t'(REG_TIMER_COMPARE): csr.csr_dr <= compare;
				csr_reg_t'(REG_TIMER_COUNTER): csr.csr_dr <= counter;
				default: csr.csr_dr <= '0;
			endcase
		end
	end

endmodule

// File: hdl/sysctl_top.sv
/* System controller subsystem */

module sysctl_top import soc_bus_pkg::*; import sysctl_pkg::*; #(
	parameter int unsigned rst_hold_cycles = 1048575,
	parameter int unsigned flash_rst_cycles = 128,
	parameter wb_data_t system_id = DEFAULT_SYSTEM_ID
) (
	input logic sys_clk,
	input logic trigger_reset,
	input wb_addr_t wb_adr_i,
	input wb_data_t wb_dat_i,
	input logic wb_we_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic [2:0] btn_i,
	input logic [3:0] pcb_revision_i,
	output wb_data_t wb_dat_o,
	output logic wb_ack_o,
	output gpio_out_t led_o,
	output irq_vec_t irq_o,
	output logic flash_rst_n_o,
	output logic periph_rst_n_o
);

	// CSR bank map
	localparam csr_bank_t gpio_bank = 5'd0;
	localparam csr_bank_t timer0_bank = 5'd1;
	localparam csr_bank_t timer1_bank = 5'd2;

	logic sys_rst;
	logic soft_reset;
	logic gpio_irq;
	logic timer0_irq;
	logic timer1_irq;

	csr_bus_if csr_gpio ();
	csr_bus_if csr_timer0 ();
	csr_bus_if csr_timer1 ();

	//----------------------------------------
	// Reset
	//----------------------------------------
	reset_sequencer #(
		.rst_hold_cycles(rst_hold_cycles),
		.flash_rst_cycles(flash_rst_cycles)
	) reset_sequencer_inst (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.soft_reset_i(soft_reset),
		.btn_i(btn_i),
		.sys_rst_o(sys_rst),
		.flash_rst_n_o(flash_rst_n_o)
	);

	assign periph_rst_n_o = ~sys_rst;

	//----------------------------------------
	// Bus bridge
	//----------------------------------------
	wb_csr_bridge wb_csr_bridge_inst (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_we_i(wb_we_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.csr_gpio(csr_gpio.bridge),
		.csr_timer0(csr_timer0.bridge),
		.csr_timer1(csr_timer1.bridge)
	);

	//----------------------------------------
	// Peripherals
	//----------------------------------------
	sysctl_gpio #(
		.csr_bank(gpio_bank),
		.system_id(system_id)
	) gpio_inst (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.gpio_i({pcb_revision_i, btn_i}),
		.led_o(led_o),
		.irq_o(gpio_irq),
		.soft_reset_o(soft_reset),
		.csr(csr_gpio.peripheral)
	);

	sysctl_timer #(
		.csr_bank(timer0_bank)
	) timer0 (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.irq_o(timer0_irq),
		.csr(csr_timer0.peripheral)
	);

	sysctl_timer #(
		.csr_bank(timer1_bank)
	) timer1 (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.irq_o(timer1_irq),
		.csr(csr_timer1.peripheral)
	);

	// Interrupt vector
	assign irq_o[IRQ_GPIO] = gpio_irq;
	assign irq_o[IRQ_TIMER0] = timer0_irq;
	assign irq_o[IRQ_TIMER1] = timer1_irq;

endmodule

// File: hdl/wb_csr_bridge.sv
/* Wishbone to CSR bridge */

module wb_csr_bridge import soc_bus_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	input wb_addr_t wb_adr_i,
	input wb_data_t wb_dat_i,
	input logic wb_we_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	output wb_data_t wb_dat_o,
	output logic wb_ack_o,
	csr_bus_if.bridge csr_gpio,
	csr_bus_if.bridge csr_timer0,
	csr_bus_if.bridge csr_timer1
);

	bridge_state_t state;
	csr_addr_t csr_a_q;
	wb_data_t csr_dw_q;
	logic csr_we_q;
	wb_data_t csr_dr_all;

	//----------------------------------------
	// CSR broadcast
	//----------------------------------------
	// Same address, strobe and data go to every link
	assign csr_gpio.csr_a = csr_a_q;
	assign csr_gpio.csr_we = csr_we_q;
	assign csr_gpio.csr_dw = csr_dw_q;
	assign csr_timer0.csr_a = csr_a_q;
	assign csr_timer0.csr_we = csr_we_q;
	assign csr_timer0.csr_dw = csr_dw_q;
	assign csr_timer1.csr_a = csr_a_q;
	assign csr_timer1.csr_we = csr_we_q;
	assign csr_timer1.csr_dw = csr_dw_q;

	// Unaddressed slaves return zero, so an OR is enough
	assign csr_dr_all = csr_gpio.csr_dr | csr_timer0.csr_dr | csr_timer1.csr_dr;

	//----------------------------------------
	// Access FSM
	//----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= IDLE;
			wb_ack_o <= 1'b0;
			csr_we_q <= 1'b0;
		end else begin
			// Single cycle pulses
			wb_ack_o <= 1'b0;
			csr_we_q <= 1'b0;
			case (state)
				IDLE: begin
					// Skip the request still held during the ack cycle
					if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
						state <= ACCESS;
					end
				end
				ACCESS: begin
					csr_we_q <= wb_we_i;
					state <= READ_WAIT;
				end
				// Peripherals register csr_dr here
				READ_WAIT: state <= ACK;
				ACK: begin
					wb_ack_o <= 1'b1;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Address, write data and read data
	always_ff @(posedge sys_clk) begin
		if (state == ACCESS) begin
			csr_a_q <= csr_addr_of(wb_adr_i);
			csr_dw_q <= wb_dat_i;
		end
		if (state == ACK) begin
			wb_dat_o <= csr_dr_all;
		end
	end

endmodule

// File: tests/sysctl_properties.sv
/* Bridge timing assertions */

module sysctl_properties (
	input logic sys_clk,
	input logic sys_rst,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_ack_o
);

	int error_count = 0;
	logic busy;
	logic req_taken;

	// New request while no access is in flight
	assign req_taken = wb_cyc_i && wb_stb_i && !wb_ack_o && !busy && !sys_rst;

	// Access in flight from the sampled request until its ack
	always_ff @(posedge sys_clk) begin
		if (sys_rst || wb_ack_o) begin
			busy <= 1'b0;
		end else if (req_taken) begin
			busy <= 1'b1;
		end
	end

	//----------------------------------------
	// Ack timing
	//----------------------------------------
	ack_single_cycle: assert property (@(posedge sys_clk) !(wb_ack_o && $past(wb_ack_o)))
	else begin
		$error("ack high for two cycles in a row");
		error_count++;
	end

	// Registered on the third edge after the request, so seen four samples later
	ack_latency: assert property (@(posedge sys_clk) disable iff (sys_rst)
		wb_ack_o == $past(req_taken, 4))
	else begin
		$error("ack does not follow the request by three cycles");
		error_count++;
	end

	ack_not_in_reset: assert property (@(posedge sys_clk) sys_rst |-> !wb_ack_o)
	else begin
		$error("ack high during system reset");
		error_count++;
	end

endmodule

bind wb_csr_bridge sysctl_properties props_inst (
	.sys_clk(sys_clk),
	.sys_rst(sys_rst),
	.wb_cyc_i(wb_cyc_i),
	.wb_stb_i(wb_stb_i),
	.wb_ack_o(wb_ack_o)
);

// File: tests/sysctl_tb.sv
/* System controller testbench */

module sysctl_tb import soc_bus_pkg::*; import sysctl_pkg::*; ();

	localparam int unsigned rst_hold_cycles = 64;
	localparam int unsigned flash_rst_cycles = 16;
	localparam wb_data_t tb_system_id = 32'hA5C3_0F17;
	localparam logic [3:0] pcb_rev = 4'hB;
	localparam logic [2:0] btn_idle = 3'b010;
	localparam int oneshot_compare = 20;
	localparam int reload_compare = 12;
	localparam int reload_pulses = 4;
	localparam int gpio_steps = 16;
	localparam int gpio_window = 8;
	// CSR bank map of the DUT
	localparam int bank_gpio = 0;
	localparam int bank_timer0 = 1;
	localparam int bank_timer1 = 2;
	localparam int bank_unused = 7;
	// Table operations
	localparam int op_write = 0;
	localparam int op_read = 1;
	localparam int op_led = 2;

	logic sys_clk;
	logic trigger_reset;
	wb_addr_t wb_adr_i;
	wb_data_t wb_dat_i;
	logic wb_we_i;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic [2:0] btn_i;
	logic [3:0] pcb_revision_i;
	wb_data_t wb_dat_o;
	logic wb_ack_o;
	gpio_out_t led_o;
	irq_vec_t irq_o;
	logic flash_rst_n_o;
	logic periph_rst_n_o;

	int seed = 88004;
	int cycle = 0;
	int timeout_limit = 0;

	// Stimulus table, one column per queue
	string t_name[$];
	int t_op[$];
	wb_addr_t t_addr[$];
	wb_data_t t_wdata[$];
	wb_data_t t_expect[$];

	sysctl_top #(
		.rst_hold_cycles(rst_hold_cycles),
		.flash_rst_cycles(flash_rst_cycles),
		.system_id(tb_system_id)
	) sysctl_top_inst (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_we_i(wb_we_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.btn_i(btn_i),
		.pcb_revision_i(pcb_revision_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.led_o(led_o),
		.irq_o(irq_o),
		.flash_rst_n_o(flash_rst_n_o),
		.periph_rst_n_o(periph_rst_n_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	//----------------------------------------
	// Failure handling
	//----------------------------------------
	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input wb_data_t expected, input wb_data_t actual);
		if (actual !== expected) begin
			fail_run($sformatf("mismatch %s expected 0x%08h actual 0x%08h", name, expected, actual));
		end
	endtask

	// Watchdog
	always @(posedge sys_clk) begin
		cycle = cycle + 1;
		if (timeout_limit != 0 && cycle >= timeout_limit) begin
			fail_run($sformatf("run timed out after %0d cycles", cycle));
		end
	end

	// Bound bridge assertions
	always @(negedge sys_clk) begin
		if (sysctl_top_inst.wb_csr_bridge_inst.props_inst.error_count != 0) begin
			fail_run("a bridge timing assertion failed");
		end
	end

	//----------------------------------------
	// Bus access
	//----------------------------------------
	// Bank in byte bits 16:12, register in 11:2
	function automatic wb_addr_t reg_addr(input int bank, input int idx);
		return (wb_addr_t'(bank) << 12) | (wb_addr_t'(idx) << 2);
	endfunction

	// Hold the request until ack, drop it in the ack cycle
	task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t wdata,
			output wb_data_t rdata);
		@(negedge sys_clk);
		wb_adr_i = adr;
		wb_dat_i = wdata;
		wb_we_i = we;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		@(negedge sys_clk);
		while (!wb_ack_o) begin
			@(negedge sys_clk);
		end
		rdata = wb_dat_o;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
	endtask

	task automatic bus_write(input wb_addr_t adr, input wb_data_t wdata);
		wb_data_t unused;
		bus_access(1'b1, adr, wdata, unused);
	endtask

	task automatic read_and_check(input string name, input wb_addr_t adr, input wb_data_t expected);
		wb_data_t rdata;
		bus_access(1'b0, adr, 32'h0, rdata);
		check_value(name, expected, rdata);
	endtask

	//----------------------------------------
	// Register table
	//----------------------------------------
	task automatic add_entry(input string name, input int op, input wb_addr_t adr,
			input wb_data_t wdata, input wb_data_t expected);
		t_name.push_back(name);
		t_op.push_back(op);
		t_addr.push_back(adr);
		t_wdata.push_back(wdata);
		t_expect.push_back(expected);
	endtask

	task automatic build_table();
		add_entry("led_write_a", op_write, reg_addr(bank_gpio, REG_GPIO_OUT), 32'h2, 32'h0);
		add_entry("led_pin_a", op_led, 32'h0, 32'h0, 32'h2);
		add_entry("led_read_a", op_read, reg_addr(bank_gpio, REG_GPIO_OUT), 32'h0, 32'h2);
		// Only two LED bits exist
		add_entry("led_write_b", op_write, reg_addr(bank_gpio, REG_GPIO_OUT), 32'hFFFF_FFFD, 32'h0);
		add_entry("led_pin_b", op_led, 32'h0, 32'h0, 32'h1);
		add_entry("led_read_b", op_read, reg_addr(bank_gpio, REG_GPIO_OUT), 32'h0, 32'h1);
		add_entry("system_id", op_read, reg_addr(bank_gpio, REG_SYSTEM_ID), 32'h0, tb_system_id);
		add_entry("gpio_in", op_read, reg_addr(bank_gpio, REG_GPIO_IN), 32'h0,
			wb_data_t'({pcb_rev, btn_idle}));
		add_entry("irq_en_write", op_write, reg_addr(bank_gpio, REG_GPIO_IRQ_EN), 32'hFFFF_FFFF,
			32'h0);
		add_entry("irq_en_read", op_read, reg_addr(bank_gpio, REG_GPIO_IRQ_EN), 32'h0, 32'h7F);
		add_entry("unused_bank", op_read, reg_addr(bank_unused, 0), 32'h0, 32'h0);
		add_entry("unused_gpio_reg", op_read, reg_addr(bank_gpio, 5), 32'h0, 32'h0);
		add_entry("t0_compare_write", op_write, reg_addr(bank_timer0, REG_TIMER_COMPARE),
			32'h1234_5678, 32'h0);
		add_entry("t0_compare_read", op_read, reg_addr(bank_timer0, REG_TIMER_COMPARE), 32'h0,
			32'h1234_5678);
		add_entry("t1_counter_write", op_write, reg_addr(bank_timer1, REG_TIMER_COUNTER), 32'd77,
			32'h0);
		add_entry("t1_counter_read", op_read, reg_addr(bank_timer1, REG_TIMER_COUNTER), 32'h0,
			32'd77);
		add_entry("t0_ctrl_read", op_read, reg_addr(bank_timer0, REG_TIMER_CTRL), 32'h0, 32'h0);
		add_entry("t1_compare_read", op_read, reg_addr(bank_timer1, REG_TIMER_COMPARE), 32'h0,
			32'h0);
	endtask

	task automatic run_table();
		wb_data_t rdata;
		for (int i = 0; i < t_name.size(); i++) begin
			case (t_op[i])
				op_write: bus_access(1'b1, t_addr[i], t_wdata[i], rdata);
				op_read: begin
					bus_access(1'b0, t_addr[i], 32'h0, rdata);
					check_value(t_name[i], t_expect[i], rdata);
				end
				default: check_value(t_name[i], t_expect[i], wb_data_t'(led_o));
			endcase
		end
	endtask

	//----------------------------------------
	// Reset checks
	//----------------------------------------
	task automatic wait_periph_low(input string name, input int limit);
		int n;
		n = 0;
		@(negedge sys_clk);
		while (periph_rst_n_o && n < limit) begin
			@(negedge sys_clk);
			n++;
		end
		if (periph_rst_n_o) begin
			fail_run($sformatf("%s did not assert the peripheral reset", name));
		end
	endtask

	// Called in the cycle the reset request goes away
	task automatic wait_reset_release(input string name);
		int flash_at;
		int n;
		flash_at = -1;
		for (int i = 0; i < rst_hold_cycles; i++) begin
			@(negedge sys_clk);
			check_value($sformatf("%s_periph_held", name), 32'h0, wb_data_t'(periph_rst_n_o));
			check_value($sformatf("%s_ack_idle", name), 32'h0, wb_data_t'(wb_ack_o));
			// Flash still held right after the request
			if (i == 0) begin
				check_value($sformatf("%s_flash_held", name), 32'h0,
					wb_data_t'(flash_rst_n_o));
			end
			if (flash_rst_n_o && flash_at < 0) begin
				flash_at = i;
			end
			// Bus request during the hold, never acknowledged
			if (i == 0) begin
				wb_adr_i = reg_addr(bank_gpio, REG_SYSTEM_ID);
				wb_we_i = 1'b0;
				wb_cyc_i = 1'b1;
				wb_stb_i = 1'b1;
			end else if (i == rst_hold_cycles / 2) begin
				wb_cyc_i = 1'b0;
				wb_stb_i = 1'b0;
			end
		end
		n = 0;
		while (!periph_rst_n_o && n < 8) begin
			@(negedge sys_clk);
			n++;
		end
		if (!periph_rst_n_o) begin
			fail_run($sformatf("%s never released the peripheral reset", name));
		end
		if (flash_at < 0) begin
			fail_run($sformatf("%s did not release the flash reset first", name));
		end
		check_value($sformatf("%s_flash_out", name), 32'h1, wb_data_t'(flash_rst_n_o));
	endtask

	//----------------------------------------
	// GPIO interrupt
	//----------------------------------------
	// Only button 1 enabled
	task automatic run_gpio_irq();
		int idx;
		int pulses;
		logic [2:0] next;
		bus_write(reg_addr(bank_gpio, REG_GPIO_IRQ_EN), 32'h1);
		for (int s = 0; s < gpio_steps; s++) begin
			idx = $unsigned($random(seed)) % 3;
			next = btn_i ^ (3'b001 << idx);
			// Three pressed would reset the system
			if (next == 3'b111) begin
				idx = (idx + 1) % 3;
				next = btn_i ^ (3'b001 << idx);
			end
			@(negedge sys_clk);
			btn_i = next;
			pulses = 0;
			repeat (gpio_window) begin
				@(negedge sys_clk);
				if (irq_o[IRQ_GPIO]) begin
					pulses++;
				end
			end
			check_value($sformatf("gpio_irq_step%0d", s), (idx == 0) ? 32'h1 : 32'h0, pulses);
		end
	endtask

	//----------------------------------------
	// Timers
	//----------------------------------------
	task automatic wait_timer1_pulse(output int waited);
		@(negedge sys_clk);
		waited = 1;
		while (!irq_o[IRQ_TIMER1]) begin
			@(negedge sys_clk);
			waited++;
		end
	endtask

	task automatic run_timers();
		int pulses;
		int waited;
		// One-shot on timer 0
		bus_write(reg_addr(bank_timer0, REG_TIMER_COMPARE), oneshot_compare);
		bus_write(reg_addr(bank_timer0, REG_TIMER_COUNTER), 32'h0);
		bus_write(reg_addr(bank_timer0, REG_TIMER_CTRL), 32'h1);
		pulses = 0;
		repeat (3 * (oneshot_compare + 1)) begin
			@(negedge sys_clk);
			if (irq_o[IRQ_TIMER0]) begin
				pulses++;
			end
		end
		check_value("timer0_oneshot_pulses", 32'h1, pulses);
		read_and_check("timer0_oneshot_ctrl", reg_addr(bank_timer0, REG_TIMER_CTRL), 32'h0);
		read_and_check("timer0_oneshot_counter", reg_addr(bank_timer0, REG_TIMER_COUNTER), 32'h0);
		// Autoreload on timer 1, period compare + 1
		bus_write(reg_addr(bank_timer1, REG_TIMER_COMPARE), reload_compare);
		bus_write(reg_addr(bank_timer1, REG_TIMER_COUNTER), 32'h0);
		bus_write(reg_addr(bank_timer1, REG_TIMER_CTRL), 32'h3);
		wait_timer1_pulse(waited);
		for (int p = 0; p < reload_pulses; p++) begin
			wait_timer1_pulse(waited);
			check_value($sformatf("timer1_period%0d", p), reload_compare + 1, waited);
		end
		bus_write(reg_addr(bank_timer1, REG_TIMER_CTRL), 32'h0);
		pulses = 0;
		repeat (3 * (reload_compare + 1)) begin
			@(negedge sys_clk);
			if (irq_o[IRQ_TIMER1]) begin
				pulses++;
			end
		end
		check_value("timer1_disabled_pulses", 32'h0, pulses);
	endtask

	//----------------------------------------
	// Software and button reset
	//----------------------------------------
	task automatic run_soft_reset();
		bus_write(reg_addr(bank_gpio, REG_GPIO_OUT), 32'h3);
		check_value("soft_reset_led_before", 32'h3, wb_data_t'(led_o));
		bus_write(reg_addr(bank_gpio, REG_HARD_RESET), 32'h0);
		wait_periph_low("soft_reset", 8);
		wait_reset_release("soft_reset");
		check_value("soft_reset_led_pin", 32'h0, wb_data_t'(led_o));
		read_and_check("soft_reset_led_read", reg_addr(bank_gpio, REG_GPIO_OUT), 32'h0);
	endtask

	task automatic run_button_reset();
		@(negedge sys_clk);
		btn_i = 3'b111;
		wait_periph_low("button_reset", 8);
		repeat (5) begin
			@(negedge sys_clk);
			check_value("button_reset_held", 32'h0, wb_data_t'(periph_rst_n_o));
		end
		btn_i = 3'b000;
		wait_reset_release("button_reset");
		read_and_check("button_reset_gpio_in", reg_addr(bank_gpio, REG_GPIO_IN),
			wb_data_t'({pcb_rev, 3'b000}));
	endtask

	//----------------------------------------
	// Test sequence
	//----------------------------------------
	initial begin
		trigger_reset = 1'b1;
		wb_adr_i = '0;
		wb_dat_i = '0;
		wb_we_i = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		btn_i = btn_idle;
		pcb_revision_i = pcb_rev;
		build_table();
		// Three resets, bus entries, GPIO steps and timer windows
		timeout_limit = 3 * (rst_hold_cycles + 40) + 10 * (t_name.size() + 30)
			+ gpio_steps * (gpio_window + 2) + 3 * (oneshot_compare + 1)
			+ (reload_pulses + 5) * (reload_compare + 1) + 100;
		repeat (10) @(negedge sys_clk);
		trigger_reset = 1'b0;
		wait_reset_release("power_on_reset");
		run_table();
		run_gpio_irq();
		run_timers();
		run_soft_reset();
		run_button_reset();
		if (sysctl_top_inst.wb_csr_bridge_inst.props_inst.error_count != 0) begin
			fail_run("a bridge timing assertion failed");
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule
